//--- Bender.yml
package:
  name: vec_alu_pipe

sources:
  - files:
      - vec_alu_pkg.sv
      - vec_alu_lane.sv
      - vec_alu_operand_stage.sv
      - vec_alu_execute_stage.sv
      - vec_alu_writeback_stage.sv
      - vec_alu_pipe.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - vec_alu_pipe_tb.sv

//--- tb_clock_gen.sv
// Testbench clock and reset source for the vector ALU pipeline.
// Free-running clock of PERIOD; reset is held low for the first three
// rising edges and released after the third one.

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter time PERIOD = 40ns
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (3) @(posedge o_clk);
    o_reset_n <= 1'b1;  // released on the third edge
  end

endmodule

//--- vec_alu_execute_stage.sv
// Ex1 stage of the vector ALU pipeline.
// Runs the two lanes, packs their compare bits into a mask field at the
// bottom of the destination and registers both results into ex2.
// A flush during ex1 drops the instruction at the ex2 register.

`timescale 1ns/1ps

module vec_alu_execute_stage (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_flush,
  input  logic                 i_ex1_valid,
  input  vec_alu_pkg::alu_op_e i_ex1_op,
  input  vec_alu_pkg::sew_e    i_ex1_sew,
  input  vec_alu_pkg::vl_t     i_ex1_vl,
  input  vec_alu_pkg::tag_t    i_ex1_tag,
  input  vec_alu_pkg::rnid_t   i_ex1_wr_rnid,
  input  vec_alu_pkg::dlen_t   i_ex1_op_a,
  input  vec_alu_pkg::dlen_t   i_ex1_vs2,
  input  vec_alu_pkg::dlen_t   i_ex1_old,
  output logic                 o_ex2_valid,
  output vec_alu_pkg::alu_op_e o_ex2_op,
  output vec_alu_pkg::tag_t    o_ex2_tag,
  output vec_alu_pkg::rnid_t   o_ex2_wr_rnid,
  output vec_alu_pkg::dlen_t   o_ex2_vec_result,
  output vec_alu_pkg::dlen_t   o_ex2_mask_result
);

  import vec_alu_pkg::*;

  dlen_t       w_vec_result;
  lane_en_t    w_lane_mask [NUM_LANES];
  int unsigned w_elem_cnt;
  mask_t       w_packed;
  mask_t       w_vl_bits;
  dlen_t       w_mask_result;

  // ----------------------------------------------------------------------
  // lanes
  // ----------------------------------------------------------------------
  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    vec_alu_lane #(
      .LANE_IDX (l)
    ) u_lane (
      .i_op     (i_ex1_op),
      .i_sew    (i_ex1_sew),
      .i_vl     (i_ex1_vl),
      .i_op_a   (i_ex1_op_a[l*LANE_W +: LANE_W]),
      .i_vs2    (i_ex1_vs2[l*LANE_W +: LANE_W]),
      .i_old    (i_ex1_old[l*LANE_W +: LANE_W]),
      .o_result (w_vec_result[l*LANE_W +: LANE_W]),
      .o_mask   (w_lane_mask[l])
    );
  end

  // ----------------------------------------------------------------------
  // mask compaction
  // ----------------------------------------------------------------------
  assign w_elem_cnt = LANE_ELEM_MAX >> i_ex1_sew;  // valid bits per lane

  // lane 0 elements first, then lane 1, in element order
  always_comb begin
    w_packed = '0;
    for (int unsigned l = 0; l < NUM_LANES; l++) begin
      for (int unsigned e = 0; e < LANE_ELEM_MAX; e++) begin
        if (e < w_elem_cnt) begin
          w_packed[l * w_elem_cnt + e] = w_lane_mask[l][e];
        end
      end
    end
  end

  assign w_vl_bits = mask_t'((32'd1 << i_ex1_vl) - 32'd1);  // ones below vl

  // packed bits below vl, old destination bits everywhere else
  assign w_mask_result = {i_ex1_old[DLEN_W-1:MAX_ELEMS],
                          (w_packed & w_vl_bits) | (i_ex1_old[MAX_ELEMS-1:0] & ~w_vl_bits)};

  // ----------------------------------------------------------------------
  // ex2 register
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ex2_valid <= 1'b0;
    end else begin
      o_ex2_valid <= i_ex1_valid & ~i_flush;  // killed in ex1
    end
  end

  always_ff @(posedge i_clk) begin
    o_ex2_op          <= i_ex1_op;
    o_ex2_tag         <= i_ex1_tag;
    o_ex2_wr_rnid     <= i_ex1_wr_rnid;
    o_ex2_vec_result  <= w_vec_result;
    o_ex2_mask_result <= w_mask_result;
  end

endmodule

//--- vec_alu_lane.sv
// One 64-bit lane of the vector ALU.
// Computes vs2 op A per element at the current SEW, keeps old data in
// tail elements (tail undisturbed) and reports compare bits for the
// body elements. LANE_IDX places the lane within the 128-bit register.

`timescale 1ns/1ps

module vec_alu_lane #(
  parameter int LANE_IDX = 0
) (
  input  vec_alu_pkg::alu_op_e  i_op,
  input  vec_alu_pkg::sew_e     i_sew,
  input  vec_alu_pkg::vl_t      i_vl,
  input  vec_alu_pkg::lane_t    i_op_a,
  input  vec_alu_pkg::lane_t    i_vs2,
  input  vec_alu_pkg::lane_t    i_old,
  output vec_alu_pkg::lane_t    o_result,
  output vec_alu_pkg::lane_en_t o_mask
);

  import vec_alu_pkg::*;

  int unsigned w_elem_cnt;
  lane_en_t    w_body_en;

  // element idx, sign-extended to the lane width
  function automatic lane_t elem_get(lane_t data, sew_e sew, int unsigned idx);
    lane_t v_out;
    case (sew)
      SEW_8:   v_out = $signed(data[(idx % 8) * 8 +: 8]);
      SEW_16:  v_out = $signed(data[(idx % 4) * 16 +: 16]);
      SEW_32:  v_out = $signed(data[(idx % 2) * 32 +: 32]);
      default: v_out = data;
    endcase
    return v_out;
  endfunction

  // write the low sew bits of val into element idx
  function automatic lane_t elem_put(lane_t data, lane_t val, sew_e sew, int unsigned idx);
    lane_t v_out;
    v_out = data;
    case (sew)
      SEW_8:   v_out[(idx % 8) * 8 +: 8]   = val[7:0];
      SEW_16:  v_out[(idx % 4) * 16 +: 16] = val[15:0];
      SEW_32:  v_out[(idx % 2) * 32 +: 32] = val[31:0];
      default: v_out = val;
    endcase
    return v_out;
  endfunction

  // ----------------------------------------------------------------------
  // body enable from vl
  // ----------------------------------------------------------------------
  assign w_elem_cnt = LANE_ELEM_MAX >> i_sew;  // 8/4/2/1

  always_comb begin
    w_body_en = '0;
    for (int unsigned e = 0; e < LANE_ELEM_MAX; e++) begin
      if (e < w_elem_cnt) begin
        w_body_en[e] = (LANE_IDX * w_elem_cnt + e) < i_vl;  // global element index
      end
    end
  end

  // ----------------------------------------------------------------------
  // per-element compute and tail merge
  // ----------------------------------------------------------------------
  always_comb begin
    lane_t v_a;
    lane_t v_b;
    lane_t v_r;
    logic  v_cmp;
    o_result = i_old;  // tail keeps old data
    o_mask   = '0;
    for (int unsigned e = 0; e < LANE_ELEM_MAX; e++) begin
      v_a = elem_get(i_op_a, i_sew, e);
      v_b = elem_get(i_vs2, i_sew, e);
      case (i_op)
        OP_ADD:  v_r = v_b + v_a;
        OP_SUB:  v_r = v_b - v_a;  // vs2 on the left
        OP_AND:  v_r = v_b & v_a;
        OP_OR:   v_r = v_b | v_a;
        OP_XOR:  v_r = v_b ^ v_a;
        default: v_r = v_b;
      endcase
      // operands are sign-extended, so a 64-bit signed compare is exact
      v_cmp = (i_op == OP_MSEQ) ? (v_b == v_a) : ($signed(v_b) < $signed(v_a));
      if (w_body_en[e]) begin
        o_result  = elem_put(o_result, v_r, i_sew, e);
        o_mask[e] = v_cmp;
      end
    end
  end

endmodule

//--- vec_alu_operand_stage.sv
// Ex0 stage of the vector ALU pipeline.
// Decodes funct6/funct3, builds operand A from vs1, the scalar or the
// 5-bit immediate, and registers the instruction into ex1.
// A flush in the issue cycle drops the instruction at the ex1 register.

`timescale 1ns/1ps

module vec_alu_operand_stage (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_ex0_valid,
  input  vec_alu_pkg::inst_t  i_ex0_inst,
  input  vec_alu_pkg::tag_t   i_ex0_tag,
  input  vec_alu_pkg::vl_t    i_ex0_vl,
  input  vec_alu_pkg::sew_e   i_ex0_sew,
  input  vec_alu_pkg::rnid_t  i_ex0_wr_rnid,
  input  vec_alu_pkg::dlen_t  i_ex0_vs1_data,
  input  vec_alu_pkg::dlen_t  i_ex0_vs2_data,
  input  vec_alu_pkg::dlen_t  i_ex0_old_data,
  input  vec_alu_pkg::xlen_t  i_ex0_rs1_data,
  input  logic                i_flush,
  output logic                o_ex1_valid,
  output vec_alu_pkg::alu_op_e o_ex1_op,
  output vec_alu_pkg::sew_e   o_ex1_sew,
  output vec_alu_pkg::vl_t    o_ex1_vl,
  output vec_alu_pkg::tag_t   o_ex1_tag,
  output vec_alu_pkg::rnid_t  o_ex1_wr_rnid,
  output vec_alu_pkg::dlen_t  o_ex1_op_a,
  output vec_alu_pkg::dlen_t  o_ex1_vs2,
  output vec_alu_pkg::dlen_t  o_ex1_old
);

  import vec_alu_pkg::*;

  logic [FUNCT6_W-1:0] w_funct6;
  logic [FUNCT3_W-1:0] w_funct3;
  logic [RS1_W-1:0]    w_simm5;
  alu_op_e             w_op;
  xlen_t               w_scalar;
  dlen_t               w_splat;
  dlen_t               w_op_a;

  assign w_funct6 = i_ex0_inst[FUNCT6_LSB +: FUNCT6_W];
  assign w_funct3 = i_ex0_inst[FUNCT3_LSB +: FUNCT3_W];
  assign w_simm5  = i_ex0_inst[RS1_LSB +: RS1_W];

  // ----------------------------------------------------------------------
  // decode
  // ----------------------------------------------------------------------
  always_comb begin
    case (w_funct6)
      F6_VADD:  w_op = OP_ADD;
      F6_VSUB:  w_op = OP_SUB;
      F6_VAND:  w_op = OP_AND;
      F6_VOR:   w_op = OP_OR;
      F6_VXOR:  w_op = OP_XOR;
      F6_VMSEQ: w_op = OP_MSEQ;
      F6_VMSLT: w_op = OP_MSLT;
      default:  w_op = OP_NONE;
    endcase
  end

  // ----------------------------------------------------------------------
  // operand A
  // ----------------------------------------------------------------------
  assign w_scalar = (w_funct3 == OPIVI) ?
                    {{(XLEN_W-RS1_W){w_simm5[RS1_W-1]}}, w_simm5} :  // sign-extended imm
                    i_ex0_rs1_data;

  // truncate to sew, then replicate across the register
  always_comb begin
    case (i_ex0_sew)
      SEW_8:   w_splat = {(DLEN_W/8){w_scalar[7:0]}};
      SEW_16:  w_splat = {(DLEN_W/16){w_scalar[15:0]}};
      SEW_32:  w_splat = {(DLEN_W/32){w_scalar[31:0]}};
      default: w_splat = {(DLEN_W/XLEN_W){w_scalar}};
    endcase
  end

  assign w_op_a = (w_funct3 == OPIVX || w_funct3 == OPIVI) ? w_splat : i_ex0_vs1_data;

  // ----------------------------------------------------------------------
  // ex1 register
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ex1_valid <= 1'b0;
    end else begin
      o_ex1_valid <= i_ex0_valid & ~i_flush;  // killed in ex0
    end
  end

  always_ff @(posedge i_clk) begin
    o_ex1_op      <= w_op;
    o_ex1_sew     <= i_ex0_sew;
    o_ex1_vl      <= i_ex0_vl;
    o_ex1_tag     <= i_ex0_tag;
    o_ex1_wr_rnid <= i_ex0_wr_rnid;
    o_ex1_op_a    <= w_op_a;
    o_ex1_vs2     <= i_ex0_vs2_data;
    o_ex1_old     <= i_ex0_old_data;
  end

endmodule

//--- vec_alu_pipe.f
vec_alu_pkg.sv
vec_alu_lane.sv
vec_alu_operand_stage.sv
vec_alu_execute_stage.sv
vec_alu_writeback_stage.sv
vec_alu_pipe.sv
tb_clock_gen.sv
vec_alu_pipe_tb.sv

//--- vec_alu_pipe.sv
// Top level of the vector integer ALU pipeline.
// ex0 decode and operand select, ex1 lane compute, ex2 write and done.
// One instruction per cycle, no back-pressure; i_flush kills ex0 and ex1.

`timescale 1ns/1ps

module vec_alu_pipe (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_ex0_valid,
  input  vec_alu_pkg::inst_t i_ex0_inst,
  input  vec_alu_pkg::tag_t  i_ex0_tag,
  input  vec_alu_pkg::vl_t   i_ex0_vl,
  input  vec_alu_pkg::sew_e  i_ex0_sew,
  input  vec_alu_pkg::rnid_t i_ex0_wr_rnid,
  input  vec_alu_pkg::dlen_t i_ex0_vs1_data,
  input  vec_alu_pkg::dlen_t i_ex0_vs2_data,
  input  vec_alu_pkg::dlen_t i_ex0_old_data,
  input  vec_alu_pkg::xlen_t i_ex0_rs1_data,
  input  logic               i_flush,
  output logic               o_wr_valid,
  output vec_alu_pkg::rnid_t o_wr_rnid,
  output vec_alu_pkg::dlen_t o_wr_data,
  output logic               o_done_valid,
  output vec_alu_pkg::tag_t  o_done_tag
);

  import vec_alu_pkg::*;

  // ex1 state
  logic    w_ex1_valid;
  alu_op_e w_ex1_op;
  sew_e    w_ex1_sew;
  vl_t     w_ex1_vl;
  tag_t    w_ex1_tag;
  rnid_t   w_ex1_wr_rnid;
  dlen_t   w_ex1_op_a;
  dlen_t   w_ex1_vs2;
  dlen_t   w_ex1_old;

  // ex2 state
  logic    w_ex2_valid;
  alu_op_e w_ex2_op;
  tag_t    w_ex2_tag;
  rnid_t   w_ex2_wr_rnid;
  dlen_t   w_ex2_vec_result;
  dlen_t   w_ex2_mask_result;

  vec_alu_operand_stage u_operand_stage (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_ex0_valid    (i_ex0_valid),
    .i_ex0_inst     (i_ex0_inst),
    .i_ex0_tag      (i_ex0_tag),
    .i_ex0_vl       (i_ex0_vl),
    .i_ex0_sew      (i_ex0_sew),
    .i_ex0_wr_rnid  (i_ex0_wr_rnid),
    .i_ex0_vs1_data (i_ex0_vs1_data),
    .i_ex0_vs2_data (i_ex0_vs2_data),
    .i_ex0_old_data (i_ex0_old_data),
    .i_ex0_rs1_data (i_ex0_rs1_data),
    .i_flush        (i_flush),
    .o_ex1_valid    (w_ex1_valid),
    .o_ex1_op       (w_ex1_op),
    .o_ex1_sew      (w_ex1_sew),
    .o_ex1_vl       (w_ex1_vl),
    .o_ex1_tag      (w_ex1_tag),
    .o_ex1_wr_rnid  (w_ex1_wr_rnid),
    .o_ex1_op_a     (w_ex1_op_a),
    .o_ex1_vs2      (w_ex1_vs2),
    .o_ex1_old      (w_ex1_old)
  );

  vec_alu_execute_stage u_execute_stage (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_flush           (i_flush),
    .i_ex1_valid       (w_ex1_valid),
    .i_ex1_op          (w_ex1_op),
    .i_ex1_sew         (w_ex1_sew),
    .i_ex1_vl          (w_ex1_vl),
    .i_ex1_tag         (w_ex1_tag),
    .i_ex1_wr_rnid     (w_ex1_wr_rnid),
    .i_ex1_op_a        (w_ex1_op_a),
    .i_ex1_vs2         (w_ex1_vs2),
    .i_ex1_old         (w_ex1_old),
    .o_ex2_valid       (w_ex2_valid),
    .o_ex2_op          (w_ex2_op),
    .o_ex2_tag         (w_ex2_tag),
    .o_ex2_wr_rnid     (w_ex2_wr_rnid),
    .o_ex2_vec_result  (w_ex2_vec_result),
    .o_ex2_mask_result (w_ex2_mask_result)
  );

  vec_alu_writeback_stage u_writeback_stage (
    .i_ex2_valid       (w_ex2_valid),
    .i_ex2_op          (w_ex2_op),
    .i_ex2_tag         (w_ex2_tag),
    .i_ex2_wr_rnid     (w_ex2_wr_rnid),
    .i_ex2_vec_result  (w_ex2_vec_result),
    .i_ex2_mask_result (w_ex2_mask_result),
    .o_wr_valid        (o_wr_valid),
    .o_wr_rnid         (o_wr_rnid),
    .o_wr_data         (o_wr_data),
    .o_done_valid      (o_done_valid),
    .o_done_tag        (o_done_tag)
  );

endmodule

//--- vec_alu_pipe_tb.sv
// Self-checking testbench for the vector ALU pipeline.
// Issues random instructions with random valid and rare flush pulses,
// predicts each write and done report in a reference model and checks
// them two cycles after issue. Prints a closing error summary.

`timescale 1ns/1ps

module vec_alu_pipe_tb;

  import vec_alu_pkg::*;

  localparam int  NUM_CYCLES = 600;
  localparam time CLK_PERIOD = 40ns;
  localparam time WATCHDOG   = (NUM_CYCLES + 60) * CLK_PERIOD;  // stimulus + reset + drain

  logic  clk;
  logic  reset_n;
  logic  ex0_valid;
  inst_t ex0_inst;
  tag_t  ex0_tag;
  vl_t   ex0_vl;
  sew_e  ex0_sew;
  rnid_t ex0_wr_rnid;
  dlen_t ex0_vs1_data;
  dlen_t ex0_vs2_data;
  dlen_t ex0_old_data;
  xlen_t ex0_rs1_data;
  logic  flush;
  logic  wr_valid;
  rnid_t wr_rnid;
  dlen_t wr_data;
  logic  done_valid;
  tag_t  done_tag;

  alu_op_e drv_op;    // op behind the driven instruction
  string   drv_name;

  // expected results in issue order
  int    q_cyc  [$];
  tag_t  q_tag  [$];
  rnid_t q_rnid [$];
  dlen_t q_data [$];
  bit    q_wr   [$];
  string q_name [$];

  int cyc        = 0;
  int value_errs = 0;
  int proto_errs = 0;

  tb_clock_gen #(.PERIOD(CLK_PERIOD)) u_clock_gen (.o_clk(clk), .o_reset_n(reset_n));

  vec_alu_pipe i_vec_alu_pipe (
    .i_clk          (clk),
    .i_reset_n      (reset_n),
    .i_ex0_valid    (ex0_valid),
    .i_ex0_inst     (ex0_inst),
    .i_ex0_tag      (ex0_tag),
    .i_ex0_vl       (ex0_vl),
    .i_ex0_sew      (ex0_sew),
    .i_ex0_wr_rnid  (ex0_wr_rnid),
    .i_ex0_vs1_data (ex0_vs1_data),
    .i_ex0_vs2_data (ex0_vs2_data),
    .i_ex0_old_data (ex0_old_data),
    .i_ex0_rs1_data (ex0_rs1_data),
    .i_flush        (flush),
    .o_wr_valid     (wr_valid),
    .o_wr_rnid      (wr_rnid),
    .o_wr_data      (wr_data),
    .o_done_valid   (done_valid),
    .o_done_tag     (done_tag)
  );

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------
  function automatic logic less_signed(lane_t x, lane_t y, int unsigned w);
    logic signed [63:0] xs;
    logic signed [63:0] ys;
    xs = x << (64 - w);  // element sign bit moved to bit 63
    ys = y << (64 - w);
    return xs < ys;
  endfunction

  function automatic dlen_t model_result(alu_op_e op, logic [2:0] funct3, sew_e sew, vl_t vl,
                                         dlen_t vs1_d, dlen_t vs2_d, dlen_t old_d,
                                         xlen_t rs1_d, logic [4:0] simm5);
    int unsigned w;
    int unsigned n;
    lane_t       emask;
    lane_t       scalar;
    lane_t       a;
    lane_t       b;
    lane_t       r;
    dlen_t       res;
    w      = 8 << sew;
    n      = DLEN_W / w;
    emask  = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
    scalar = (funct3 == OPIVI) ? {{59{simm5[4]}}, simm5} : rs1_d;
    res    = old_d;  // tail and mask upper bits stay old
    for (int unsigned i = 0; i < n; i++) begin
      b = lane_t'(vs2_d >> (i * w)) & emask;
      a = (funct3 == OPIVV) ? (lane_t'(vs1_d >> (i * w)) & emask) : (scalar & emask);
      case (op)
        OP_ADD:  r = b + a;
        OP_SUB:  r = b - a;
        OP_AND:  r = b & a;
        OP_OR:   r = b | a;
        OP_XOR:  r = b ^ a;
        OP_MSEQ: r = lane_t'(b == a);
        default: r = lane_t'(less_signed(b, a, w));
      endcase
      if (i < vl) begin
        if (op == OP_MSEQ || op == OP_MSLT) begin
          res[i] = r[0];  // packed from bit 0
        end else begin
          res = (res & ~(dlen_t'(emask) << (i * w))) | (dlen_t'(r & emask) << (i * w));
        end
      end
    end
    return res;
  endfunction

  always @(posedge clk) begin
    if (reset_n) begin
      cyc = cyc + 1;
      // flush in the cycle after issue drops the newest entry
      if (flush && q_cyc.size() != 0 && q_cyc[$] == cyc) begin
        void'(q_cyc.pop_back());
        void'(q_tag.pop_back());
        void'(q_rnid.pop_back());
        void'(q_data.pop_back());
        void'(q_wr.pop_back());
        void'(q_name.pop_back());
      end
      if (ex0_valid && !flush) begin
        q_cyc.push_back(cyc + 1);
        q_tag.push_back(ex0_tag);
        q_rnid.push_back(ex0_wr_rnid);
        q_data.push_back(model_result(drv_op, ex0_inst[FUNCT3_LSB +: 3], ex0_sew, ex0_vl,
                                      ex0_vs1_data, ex0_vs2_data, ex0_old_data,
                                      ex0_rs1_data, ex0_inst[RS1_LSB +: 5]));
        q_wr.push_back(drv_op != OP_NONE);
        q_name.push_back(drv_name);
      end
    end
  end

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  task automatic check_wr(string name, rnid_t exp_rnid, dlen_t exp_data,
                          rnid_t act_rnid, dlen_t act_data);
    if (exp_rnid !== act_rnid || exp_data !== act_data) begin
      $display("Fail %s: expected rnid %0d data %h, actual rnid %0d data %h",
               name, exp_rnid, exp_data, act_rnid, act_data);
      value_errs++;
    end
  endtask

  task automatic check_done(string name, tag_t exp_tag, tag_t act_tag);
    if (exp_tag !== act_tag) begin
      $display("Fail %s: expected tag %0d, actual tag %0d", name, exp_tag, act_tag);
      value_errs++;
    end
  endtask

  // outputs sampled mid-cycle
  always @(negedge clk) begin
    if (reset_n) begin
      if (q_cyc.size() != 0 && q_cyc[0] <= cyc) begin
        if (done_valid !== 1'b1) begin
          $display("%s gave no done report in cycle %0d", q_name[0], cyc);
          proto_errs++;
        end else begin
          check_done(q_name[0], q_tag[0], done_tag);
          if (q_wr[0] && wr_valid !== 1'b1) begin
            $display("%s gave no register write", q_name[0]);
            proto_errs++;
          end else if (q_wr[0]) begin
            check_wr(q_name[0], q_rnid[0], q_data[0], wr_rnid, wr_data);
          end else if (wr_valid !== 1'b0) begin
            $display("%s wrote a register although its funct6 is unsupported", q_name[0]);
            proto_errs++;
          end
        end
        void'(q_cyc.pop_front());
        void'(q_tag.pop_front());
        void'(q_rnid.pop_front());
        void'(q_data.pop_front());
        void'(q_wr.pop_front());
        void'(q_name.pop_front());
      end else if (done_valid !== 1'b0 || wr_valid !== 1'b0) begin
        $display("output valid in cycle %0d with no instruction due", cyc);
        proto_errs++;
      end
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  function automatic logic [5:0] funct6_of(alu_op_e op);
    case (op)
      OP_ADD:  return F6_VADD;
      OP_SUB:  return F6_VSUB;
      OP_AND:  return F6_VAND;
      OP_OR:   return F6_VOR;
      OP_XOR:  return F6_VXOR;
      OP_MSEQ: return F6_VMSEQ;
      OP_MSLT: return F6_VMSLT;
      default: return 6'b100000;  // vsaddu, which the decoder does not know
    endcase
  endfunction

  function automatic dlen_t rand_dlen();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  initial begin
    int unsigned sel;
    alu_op_e     v_op;
    sew_e        v_sew;
    vl_t         v_vl;
    logic [2:0]  v_f3;
    string       v_form;
    dlen_t       v_vs1;
    dlen_t       v_vs2;
    void'($urandom(32'hcf7a));
    ex0_valid    = 1'b0;
    ex0_inst     = '0;
    ex0_tag      = '0;
    ex0_vl       = '0;
    ex0_sew      = SEW_8;
    ex0_wr_rnid  = '0;
    ex0_vs1_data = '0;
    ex0_vs2_data = '0;
    ex0_old_data = '0;
    ex0_rs1_data = '0;
    flush        = 1'b0;
    drv_op       = OP_NONE;
    drv_name     = "idle";
    wait (reset_n === 1'b1);
    for (int n = 0; n < NUM_CYCLES; n++) begin
      @(posedge clk);
      sel   = $urandom % 16;
      v_op  = (sel >= 14) ? OP_NONE : alu_op_e'(sel % 7);
      v_sew = sew_e'($urandom % 4);
      v_vl  = vl_t'($urandom % ((16 >> v_sew) + 1));
      case ($urandom % 3)
        0: begin
          v_f3   = OPIVV;
          v_form = "vv";
        end
        1: begin
          v_f3   = OPIVX;
          v_form = "vx";
        end
        default: begin
          v_f3   = OPIVI;
          v_form = "vi";
        end
      endcase
      v_vs1 = rand_dlen();
      v_vs2 = rand_dlen();
      if ($urandom % 4 == 0) begin
        v_vs2 = {v_vs1[127:64], v_vs2[63:0]};  // some equal elements for vmseq
      end
      ex0_valid    <= ($urandom % 4 != 0);
      flush        <= ($urandom % 16 == 0);  // rare
      ex0_inst     <= {funct6_of(v_op), 1'b1, 5'($urandom), 5'($urandom), v_f3,
                       5'($urandom), 7'h57};
      ex0_tag      <= tag_t'($urandom);
      ex0_vl       <= v_vl;
      ex0_sew      <= v_sew;
      ex0_wr_rnid  <= rnid_t'($urandom);
      ex0_vs1_data <= v_vs1;
      ex0_vs2_data <= v_vs2;
      ex0_old_data <= rand_dlen();
      ex0_rs1_data <= {$urandom, $urandom};
      drv_op       <= v_op;
      drv_name     <= $sformatf("%s.%s e%0d vl%0d #%0d", v_op.name(), v_form,
                                8 << v_sew, v_vl, n);
    end
    @(posedge clk);
    ex0_valid <= 1'b0;
    flush     <= 1'b0;
    while (q_cyc.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);  // no stray outputs after drain
    $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG);
    $display("timeout: the pipeline did not drain within %0t", WATCHDOG);
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- vec_alu_pkg.sv
// Shared widths, data types, opcode enum and instruction field positions
// for the three-stage vector integer ALU pipeline.
// Modules pull these in with a wildcard import in the body and use
// scoped names for port types.

package vec_alu_pkg;

  // ----------------------------------------------------------------------
  // datapath geometry
  // ----------------------------------------------------------------------
  localparam int DLEN_W        = 128;
  localparam int LANE_W        = 64;
  localparam int NUM_LANES     = DLEN_W / LANE_W;
  localparam int XLEN_W        = 64;
  localparam int LANE_ELEM_MAX = LANE_W / 8;      // elements per lane at sew 8
  localparam int MAX_ELEMS     = DLEN_W / 8;      // elements per register at sew 8

  // ----------------------------------------------------------------------
  // instruction fields
  // ----------------------------------------------------------------------
  localparam int FUNCT6_LSB = 26;
  localparam int FUNCT6_W   = 6;
  localparam int RS1_LSB    = 15;
  localparam int RS1_W      = 5;                  // also the simm5 field
  localparam int FUNCT3_LSB = 12;
  localparam int FUNCT3_W   = 3;

  // operand forms
  localparam logic [FUNCT3_W-1:0] OPIVV = 3'b000;
  localparam logic [FUNCT3_W-1:0] OPIVX = 3'b100;
  localparam logic [FUNCT3_W-1:0] OPIVI = 3'b011;

  // supported funct6 encodings
  localparam logic [FUNCT6_W-1:0] F6_VADD  = 6'b000000;
  localparam logic [FUNCT6_W-1:0] F6_VSUB  = 6'b000010;
  localparam logic [FUNCT6_W-1:0] F6_VAND  = 6'b001001;
  localparam logic [FUNCT6_W-1:0] F6_VOR   = 6'b001010;
  localparam logic [FUNCT6_W-1:0] F6_VXOR  = 6'b001011;
  localparam logic [FUNCT6_W-1:0] F6_VMSEQ = 6'b011000;
  localparam logic [FUNCT6_W-1:0] F6_VMSLT = 6'b011011;

  // ----------------------------------------------------------------------
  // types
  // ----------------------------------------------------------------------
  typedef logic [DLEN_W-1:0]                  dlen_t;
  typedef logic [LANE_W-1:0]                  lane_t;
  typedef logic [XLEN_W-1:0]                  xlen_t;
  typedef logic [31:0]                        inst_t;
  typedef logic [$clog2(MAX_ELEMS+1)-1:0]     vl_t;    // 0 .. 16 elements
  typedef logic [5:0]                         tag_t;
  typedef logic [6:0]                         rnid_t;
  typedef logic [LANE_ELEM_MAX-1:0]           lane_en_t;
  typedef logic [MAX_ELEMS-1:0]               mask_t;

  typedef enum logic [1:0] {
    SEW_8  = 2'd0,
    SEW_16 = 2'd1,
    SEW_32 = 2'd2,
    SEW_64 = 2'd3
  } sew_e;

  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_MSEQ = 3'd5,
    OP_MSLT = 3'd6,
    OP_NONE = 3'd7   // unsupported funct6, reported done without a write
  } alu_op_e;

endpackage

//--- vec_alu_writeback_stage.sv
// Ex2 stage of the vector ALU pipeline.
// Presents the ex2 registers as the register write and the done report.
// Compares write the mask result; OP_NONE reports done but never writes.

`timescale 1ns/1ps

module vec_alu_writeback_stage (
  input  logic                 i_ex2_valid,
  input  vec_alu_pkg::alu_op_e i_ex2_op,
  input  vec_alu_pkg::tag_t    i_ex2_tag,
  input  vec_alu_pkg::rnid_t   i_ex2_wr_rnid,
  input  vec_alu_pkg::dlen_t   i_ex2_vec_result,
  input  vec_alu_pkg::dlen_t   i_ex2_mask_result,
  output logic                 o_wr_valid,
  output vec_alu_pkg::rnid_t   o_wr_rnid,
  output vec_alu_pkg::dlen_t   o_wr_data,
  output logic                 o_done_valid,
  output vec_alu_pkg::tag_t    o_done_tag
);

  import vec_alu_pkg::*;

  logic w_is_cmp;

  assign w_is_cmp = (i_ex2_op == OP_MSEQ) || (i_ex2_op == OP_MSLT);

  // register write
  assign o_wr_valid = i_ex2_valid & (i_ex2_op != OP_NONE);  // no write for unsupported op
  assign o_wr_rnid  = i_ex2_wr_rnid;
  assign o_wr_data  = w_is_cmp ? i_ex2_mask_result : i_ex2_vec_result;

  // done report, every surviving instruction
  assign o_done_valid = i_ex2_valid;
  assign o_done_tag   = i_ex2_tag;

endmodule
